// ==== logic/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// core word size
// data path and address path share it
`define XLEN 32

// architectural integer registers
// entry zero reads as zero
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== logic/riscv_pkg.sv ====
`default_nettype none

`include "riscv_macros.svh"

package riscv_pkg;

  // basic words
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [`XLEN-1:0] data_t;
  typedef logic [4:0]       reg_idx_t;

  // alu operations, pass_b carries lui's immediate through
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  // writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_t;

  // fetch to decode
  typedef struct packed {
    logic  valid;
    addr_t pc;
    data_t instr;
  } if_to_id_t;

  // decode to execute, operands already read
  typedef struct packed {
    logic     valid;
    addr_t    pc;
    data_t    rs1_data;
    data_t    rs2_data;
    data_t    imm;
    reg_idx_t rd;
    alu_op_t  alu_op;
    logic     use_imm;
    wb_sel_t  wb_sel;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     branch_ne;
    logic     jump;
  } id_to_ex_t;

  // execute to memory
  typedef struct packed {
    logic     valid;
    data_t    alu_result;
    data_t    store_data;
    addr_t    pc_plus4;
    reg_idx_t rd;
    wb_sel_t  wb_sel;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
  } ex_to_mem_t;

  // memory to writeback
  typedef struct packed {
    logic     valid;
    data_t    alu_result;
    data_t    mem_data;
    addr_t    pc_plus4;
    reg_idx_t rd;
    wb_sel_t  wb_sel;
    logic     reg_write;
  } mem_to_wb_t;

  // redirect from execute back to fetch
  typedef struct packed {
    logic  redirect;
    addr_t target;
  } ex_to_if_t;

endpackage

`default_nettype wire

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pipeline register, payload is a stage struct
module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // all-zero payload is a bubble, valid bit low
  // flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  riscv_pkg::ex_to_if_t  ex_to_if,
  output riscv_pkg::addr_t      imem_address,
  input  riscv_pkg::data_t      imem_data,
  output riscv_pkg::if_to_id_t  if_to_id
);

  import riscv_pkg::*;

  addr_t pc;

  // next pc
  // redirect beats stall, else sequential
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (ex_to_if.redirect) begin
      pc <= ex_to_if.target;
    end else if (!stall) begin
      pc <= pc + addr_t'(4);
    end
  end

  // instruction memory reads combinationally from pc
  assign imem_address = pc;

  // every fetch is valid here
  // bubbles come from the if/id flush
  assign if_to_id.valid = 1'b1;
  assign if_to_id.pc    = pc;
  assign if_to_id.instr = imem_data;

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  riscv_pkg::if_to_id_t  if_to_id,
  input  logic                  wb_write,
  input  riscv_pkg::reg_idx_t   wb_rd,
  input  riscv_pkg::data_t      wb_data,
  output riscv_pkg::reg_idx_t   rs1,
  output riscv_pkg::reg_idx_t   rs2,
  output logic                  uses_rs1,
  output logic                  uses_rs2,
  output riscv_pkg::id_to_ex_t  id_to_ex
);

  import riscv_pkg::*;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  data_t      regs [`NUM_REGS];
  data_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_b;
  data_t      imm_j;
  data_t      imm_u;
  logic       legal;
  logic       use1;
  logic       use2;

  assign instr  = if_to_id.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // register file
  // x0 never written, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // control decode
  always_comb begin
    legal              = 1'b0;
    use1               = 1'b0;
    use2               = 1'b0;
    id_to_ex.imm       = imm_i;
    id_to_ex.alu_op    = ALU_ADD;
    id_to_ex.use_imm   = 1'b0;
    id_to_ex.wb_sel    = WB_ALU;
    id_to_ex.reg_write = 1'b0;
    id_to_ex.mem_read  = 1'b0;
    id_to_ex.mem_write = 1'b0;
    id_to_ex.branch    = 1'b0;
    id_to_ex.branch_ne = 1'b0;
    id_to_ex.jump      = 1'b0;
    case (opcode)
      OP_LUI: begin
        legal              = 1'b1;
        id_to_ex.imm       = imm_u;
        id_to_ex.alu_op    = ALU_PASS_B;
        id_to_ex.use_imm   = 1'b1;
        id_to_ex.reg_write = 1'b1;
      end
      OP_JAL: begin
        // link value is pc+4, target from execute
        legal              = 1'b1;
        id_to_ex.imm       = imm_j;
        id_to_ex.wb_sel    = WB_PC4;
        id_to_ex.reg_write = 1'b1;
        id_to_ex.jump      = 1'b1;
      end
      OP_BRANCH: begin
        // beq and bne only
        legal              = (funct3[2:1] == 2'b00);
        use1               = 1'b1;
        use2               = 1'b1;
        id_to_ex.imm       = imm_b;
        id_to_ex.alu_op    = ALU_SUB;
        id_to_ex.branch    = 1'b1;
        id_to_ex.branch_ne = funct3[0];
      end
      OP_LOAD: begin
        // word loads only
        legal              = (funct3 == 3'b010);
        use1               = 1'b1;
        id_to_ex.use_imm   = 1'b1;
        id_to_ex.wb_sel    = WB_MEM;
        id_to_ex.reg_write = 1'b1;
        id_to_ex.mem_read  = 1'b1;
      end
      OP_STORE: begin
        legal              = (funct3 == 3'b010);
        use1               = 1'b1;
        use2               = 1'b1;
        id_to_ex.imm       = imm_s;
        id_to_ex.use_imm   = 1'b1;
        id_to_ex.mem_write = 1'b1;
      end
      OP_IMM, OP_REG: begin
        use1               = 1'b1;
        use2               = (opcode == OP_REG);
        id_to_ex.use_imm   = (opcode == OP_IMM);
        id_to_ex.reg_write = 1'b1;
        legal              = 1'b1;
        case (funct3)
          3'b000:  id_to_ex.alu_op = ALU_ADD;
          3'b111:  id_to_ex.alu_op = ALU_AND;
          3'b110:  id_to_ex.alu_op = ALU_OR;
          3'b100:  id_to_ex.alu_op = ALU_XOR;
          3'b010:  id_to_ex.alu_op = ALU_SLT;
          default: legal = 1'b0;
        endcase
        // register form, sub is the only alternate funct7
        if (opcode == OP_REG) begin
          if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
            id_to_ex.alu_op = ALU_SUB;
          end else if (funct7 != 7'b0000000) begin
            legal = 1'b0;
          end
        end
      end
      default: legal = 1'b0;
    endcase
  end

  // unsupported or bubble, nothing downstream acts on it
  assign id_to_ex.valid = if_to_id.valid && legal;
  assign id_to_ex.pc    = if_to_id.pc;
  assign id_to_ex.rd    = instr[11:7];

  // hazard sees only real source reads
  assign uses_rs1 = id_to_ex.valid && use1;
  assign uses_rs2 = id_to_ex.valid && use2;

  // write-first read ports
  // same-cycle writeback value bypasses the array
  assign id_to_ex.rs1_data = (rs1 == '0) ? '0 :
                             (wb_write && wb_rd == rs1) ? wb_data : regs[rs1];
  assign id_to_ex.rs2_data = (rs2 == '0) ? '0 :
                             (wb_write && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  riscv_pkg::id_to_ex_t   id_to_ex,
  output riscv_pkg::ex_to_mem_t  ex_to_mem,
  output riscv_pkg::ex_to_if_t   ex_to_if
);

  import riscv_pkg::*;

  data_t operand_a;
  data_t operand_b;
  data_t alu_result;
  logic  equal;
  logic  taken;

  assign operand_a = id_to_ex.rs1_data;

  // register or immediate second operand
  assign operand_b = id_to_ex.use_imm ? id_to_ex.imm : id_to_ex.rs2_data;

  // alu
  always_comb begin
    case (id_to_ex.alu_op)
      ALU_ADD:    alu_result = operand_a + operand_b;
      ALU_SUB:    alu_result = operand_a - operand_b;
      ALU_AND:    alu_result = operand_a & operand_b;
      ALU_OR:     alu_result = operand_a | operand_b;
      ALU_XOR:    alu_result = operand_a ^ operand_b;
      ALU_SLT:    alu_result = data_t'($signed(operand_a) < $signed(operand_b));
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

  // beq/bne compare the two registers directly
  assign equal = (id_to_ex.rs1_data == id_to_ex.rs2_data);

  // bne flips the sense of the compare
  assign taken = id_to_ex.valid &&
                 (id_to_ex.jump || (id_to_ex.branch && (equal ^ id_to_ex.branch_ne)));

  // both branch and jal targets are pc relative
  assign ex_to_if.redirect = taken;
  assign ex_to_if.target   = id_to_ex.pc + id_to_ex.imm;

  // forward to memory stage
  assign ex_to_mem.valid      = id_to_ex.valid;
  assign ex_to_mem.alu_result = alu_result;
  assign ex_to_mem.store_data = id_to_ex.rs2_data;
  assign ex_to_mem.pc_plus4   = id_to_ex.pc + addr_t'(4);
  assign ex_to_mem.rd         = id_to_ex.rd;
  assign ex_to_mem.wb_sel     = id_to_ex.wb_sel;
  assign ex_to_mem.reg_write  = id_to_ex.reg_write;
  assign ex_to_mem.mem_read   = id_to_ex.mem_read;
  assign ex_to_mem.mem_write  = id_to_ex.mem_write;

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  riscv_pkg::reg_idx_t    rs1,
  input  riscv_pkg::reg_idx_t    rs2,
  input  logic                   uses_rs1,
  input  logic                   uses_rs2,
  input  riscv_pkg::id_to_ex_t   id_to_ex,
  input  riscv_pkg::ex_to_mem_t  ex_to_mem,
  input  logic                   redirect,
  output logic                   stall,
  output logic                   flush_if_id,
  output logic                   flush_id_ex
);

  import riscv_pkg::*;

  logic ex_writes;
  logic mem_writes;
  logic hit_rs1;
  logic hit_rs2;
  logic raw;

  // older writers still in flight, x0 never counts
  assign ex_writes  = id_to_ex.valid && id_to_ex.reg_write && (id_to_ex.rd != '0);
  assign mem_writes = ex_to_mem.valid && ex_to_mem.reg_write && (ex_to_mem.rd != '0);

  // no forwarding, so any match waits for writeback
  // load/use falls out of the same check
  assign hit_rs1 = uses_rs1 && ((ex_writes && id_to_ex.rd == rs1) ||
                                (mem_writes && ex_to_mem.rd == rs1));
  assign hit_rs2 = uses_rs2 && ((ex_writes && id_to_ex.rd == rs2) ||
                                (mem_writes && ex_to_mem.rd == rs2));
  assign raw     = hit_rs1 || hit_rs2;

  // redirect kills the stalled instruction anyway
  assign stall       = raw && !redirect;
  assign flush_if_id = redirect;
  // bubble into execute while decode waits
  assign flush_id_ex = redirect || raw;

endmodule

`default_nettype wire

// ==== logic/riscv_pipelined.sv ====
`timescale 1ns/1ps
`default_nettype none

// five-stage core, separate instruction and data ports
module riscv_pipelined (
  input  logic             clk,
  input  logic             reset,

  output riscv_pkg::addr_t memory_instr__address,
  output riscv_pkg::data_t memory_instr__write_data,
  output logic [3:0]       memory_instr__write_enable,
  input  riscv_pkg::data_t memory_instr__read_data,

  output riscv_pkg::addr_t memory_data__address,
  output riscv_pkg::data_t memory_data__write_data,
  output logic [3:0]       memory_data__write_enable,
  input  riscv_pkg::data_t memory_data__read_data
);

  import riscv_pkg::*;

  if_to_id_t  if_to_id_d;
  if_to_id_t  if_to_id_q;
  id_to_ex_t  id_to_ex_d;
  id_to_ex_t  id_to_ex_q;
  ex_to_mem_t ex_to_mem_d;
  ex_to_mem_t ex_to_mem_q;
  mem_to_wb_t mem_to_wb_d;
  mem_to_wb_t mem_to_wb_q;
  ex_to_if_t  ex_to_if;

  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     uses_rs1;
  logic     uses_rs2;
  logic     stall;
  logic     flush_if_id;
  logic     flush_id_ex;

  logic     wb_write;
  data_t    wb_data;

  // fetch
  fetch_stage u_fetch_stage (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .ex_to_if     (ex_to_if),
    .imem_address (memory_instr__address),
    .imem_data    (memory_instr__read_data),
    .if_to_id     (if_to_id_d)
  );

  // instruction port is read only
  assign memory_instr__write_data   = '0;
  assign memory_instr__write_enable = 4'b0000;

  pipe_reg #(.payload_t(if_to_id_t)) u_if_id (
    .clk   (clk),
    .reset (reset),
    .stall (stall),
    .flush (flush_if_id),
    .d     (if_to_id_d),
    .q     (if_to_id_q)
  );

  // decode and register file
  decode_stage u_decode_stage (
    .clk      (clk),
    .reset    (reset),
    .if_to_id (if_to_id_q),
    .wb_write (wb_write),
    .wb_rd    (mem_to_wb_q.rd),
    .wb_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .id_to_ex (id_to_ex_d)
  );

  hazard_unit u_hazard_unit (
    .rs1         (rs1),
    .rs2         (rs2),
    .uses_rs1    (uses_rs1),
    .uses_rs2    (uses_rs2),
    .id_to_ex    (id_to_ex_q),
    .ex_to_mem   (ex_to_mem_q),
    .redirect    (ex_to_if.redirect),
    .stall       (stall),
    .flush_if_id (flush_if_id),
    .flush_id_ex (flush_id_ex)
  );

  // id/ex never holds, a stall turns into a bubble here
  pipe_reg #(.payload_t(id_to_ex_t)) u_id_ex (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (flush_id_ex),
    .d     (id_to_ex_d),
    .q     (id_to_ex_q)
  );

  // execute
  execute_stage u_execute_stage (
    .id_to_ex  (id_to_ex_q),
    .ex_to_mem (ex_to_mem_d),
    .ex_to_if  (ex_to_if)
  );

  pipe_reg #(.payload_t(ex_to_mem_t)) u_ex_mem (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (1'b0),
    .d     (ex_to_mem_d),
    .q     (ex_to_mem_q)
  );

  // memory stage, word accesses only
  assign memory_data__address      = ex_to_mem_q.alu_result;
  assign memory_data__write_data   = ex_to_mem_q.store_data;
  assign memory_data__write_enable = (ex_to_mem_q.valid && ex_to_mem_q.mem_write) ?
                                     4'b1111 : 4'b0000;

  // capture load data alongside the rest of the bundle
  always_comb begin
    mem_to_wb_d.valid      = ex_to_mem_q.valid;
    mem_to_wb_d.alu_result = ex_to_mem_q.alu_result;
    mem_to_wb_d.mem_data   = ex_to_mem_q.mem_read ? memory_data__read_data : '0;
    mem_to_wb_d.pc_plus4   = ex_to_mem_q.pc_plus4;
    mem_to_wb_d.rd         = ex_to_mem_q.rd;
    mem_to_wb_d.wb_sel     = ex_to_mem_q.wb_sel;
    mem_to_wb_d.reg_write  = ex_to_mem_q.reg_write;
  end

  pipe_reg #(.payload_t(mem_to_wb_t)) u_mem_wb (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (1'b0),
    .d     (mem_to_wb_d),
    .q     (mem_to_wb_q)
  );

  // writeback select
  always_comb begin
    case (mem_to_wb_q.wb_sel)
      WB_MEM:  wb_data = mem_to_wb_q.mem_data;
      WB_PC4:  wb_data = mem_to_wb_q.pc_plus4;
      default: wb_data = mem_to_wb_q.alu_result;
    endcase
  end

  assign wb_write = mem_to_wb_q.valid && mem_to_wb_q.reg_write;

endmodule

`default_nettype wire

// ==== dv/riscv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_tb;

  localparam int          STEPS   = 1000;
  localparam int          TIMEOUT = 5000;
  localparam int          DRAIN   = 20;
  localparam logic [6:0]  OPC_IMM  = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD = 7'b0000011;

  logic        clk;
  logic        reset;
  logic [31:0] memory_instr__address;
  logic [31:0] memory_instr__write_data;
  logic [3:0]  memory_instr__write_enable;
  logic [31:0] memory_instr__read_data;
  logic [31:0] memory_data__address;
  logic [31:0] memory_data__write_data;
  logic [3:0]  memory_data__write_enable;
  logic [31:0] memory_data__read_data;

  // 1 KiB each as 256 words
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  // architectural model state
  logic [31:0] ref_regs [32];
  logic [31:0] ref_mem [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  int          wr_ptr;
  int          store_idx;
  int          test_errors;
  int          test_num;
  int          tests_failed;
  int unsigned seed_state;
  logic        pend_valid;
  logic [31:0] pend_addr;
  logic [31:0] pend_data;

  riscv_pipelined riscv_pipelined_i (
    .clk                        (clk),
    .reset                      (reset),
    .memory_instr__address      (memory_instr__address),
    .memory_instr__write_data   (memory_instr__write_data),
    .memory_instr__write_enable (memory_instr__write_enable),
    .memory_instr__read_data    (memory_instr__read_data),
    .memory_data__address       (memory_data__address),
    .memory_data__write_data    (memory_data__write_data),
    .memory_data__write_enable  (memory_data__write_enable),
    .memory_data__read_data     (memory_data__read_data)
  );

  // combinational read ports
  assign memory_instr__read_data = imem[memory_instr__address[9:2]];
  assign memory_data__read_data  = dmem[memory_data__address[9:2]];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // initial data image
  // every word distinct
  function automatic logic [31:0] fill_word(input int i);
    return 32'hd00d_0000 | (i << 2);
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  // sw only
  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // architectural interpreter
  // records every store in program order
  function automatic void run_reference(input int steps);
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    int          i;
    for (i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
    end
    exp_addr.delete();
    exp_data.delete();
    pc = '0;
    for (i = 0; i < steps; i++) begin
      ins     = imem[pc[9:2]];
      rd      = ins[11:7];
      f3      = ins[14:12];
      a       = ref_regs[ins[19:15]];
      b       = ref_regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 4;
      case (ins[6:0])
        7'b0110111: ref_regs[rd] = {ins[31:12], 12'b0};
        7'b1101111: begin
          ref_regs[rd] = pc + 4;
          next_pc      = pc + imm_j;
        end
        // beq when f3 is 0 and bne when 1
        7'b1100011: if ((a == b) != f3[0]) next_pc = pc + imm_b;
        7'b0000011: begin
          addr         = a + imm_i;
          ref_regs[rd] = ref_mem[addr[9:2]];
        end
        7'b0100011: begin
          addr                = a + imm_s;
          ref_mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        7'b0010011, 7'b0110011: begin
          if (ins[6:0] == 7'b0010011) b = imm_i;
          case (f3)
            3'b000:  ref_regs[rd] = (ins[5] && ins[30]) ? a - b : a + b;
            3'b111:  ref_regs[rd] = a & b;
            3'b110:  ref_regs[rd] = a | b;
            3'b100:  ref_regs[rd] = a ^ b;
            3'b010:  ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        default: ;
      endcase
      ref_regs[0] = '0;
      pc          = next_pc;
    end
  endfunction

  // store monitor sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && memory_data__write_enable !== 4'b0000) begin
      if (memory_data__write_enable !== 4'b1111) begin
        $display("Mismatch memory_data__write_enable store %0d: expected %h, got %h",
                 store_idx, 4'b1111, memory_data__write_enable);
        test_errors++;
      end
      if (store_idx >= exp_addr.size()) begin
        $display("unexpected store number %0d to address %h after the expected sequence",
                 store_idx, memory_data__address);
        test_errors++;
      end else begin
        if (memory_data__address !== exp_addr[store_idx]) begin
          $display("Mismatch memory_data__address store %0d: expected %h, got %h",
                   store_idx, exp_addr[store_idx], memory_data__address);
          test_errors++;
        end
        if (memory_data__write_data !== exp_data[store_idx]) begin
          $display("Mismatch memory_data__write_data store %0d: expected %h, got %h",
                   store_idx, exp_data[store_idx], memory_data__write_data);
          test_errors++;
        end
      end
      store_idx++;
      pend_valid = 1'b1;
      pend_addr  = memory_data__address;
      pend_data  = memory_data__write_data;
    end
  end

  // instruction port stays read only
  always @(negedge clk) begin
    if (!reset) begin
      if (memory_instr__write_enable !== 4'b0000) begin
        $display("Mismatch memory_instr__write_enable: expected %h, got %h",
                 4'b0000, memory_instr__write_enable);
        test_errors++;
      end
      if (memory_instr__write_data !== 32'h0000_0000) begin
        $display("Mismatch memory_instr__write_data: expected %h, got %h",
                 32'h0000_0000, memory_instr__write_data);
        test_errors++;
      end
    end
  end

  // memory write lands 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (pend_valid) begin
      dmem[pend_addr[9:2]] = pend_data;
      pend_valid           = 1'b0;
    end
  end

  task automatic put(input logic [31:0] word);
    imem[wr_ptr] = word;
    wr_ptr++;
  endtask

  task automatic store_all_regs(input int base);
    int i;
    for (i = 1; i < 32; i++) begin
      put(s_type(base + 4 * i, i, 0));
    end
  endtask

  // hold the core in reset and clear both memories
  task automatic start_program();
    int i;
    @(posedge clk);
    #1 reset = 1'b1;
    // any late store commits before the refill
    @(posedge clk);
    #2;
    for (i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = fill_word(i);
    end
    wr_ptr = 0;
  endtask

  // end with a self jump
  // then release reset and wait for the last store
  task automatic finish_program(input string name);
    int cycles;
    put(jal_word(0, 0));
    run_reference(STEPS);
    store_idx   = 0;
    test_errors = 0;
    test_num++;
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (store_idx < exp_addr.size() && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (store_idx < exp_addr.size()) begin
      $display("timed out after %0d cycles with %0d of %0d stores seen",
               cycles, store_idx, exp_addr.size());
      test_errors++;
    end
    // stray stores after the last one show up here
    cycles = 0;
    while (cycles < DRAIN) begin
      @(posedge clk);
      cycles++;
    end
    if (test_errors != 0) tests_failed++;
    $display("test %0d %s: %s, %0d stores expected, %0d seen", test_num, name,
             (test_errors == 0) ? "pass" : "fail", exp_addr.size(), store_idx);
  endtask

  task automatic build_random_program(input int count);
    int          n;
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [31:0] offset;
    // seed the small register set first
    for (n = 1; n < 8; n++) begin
      put(i_type($urandom % 4096, 0, 3'b000, n, OPC_IMM));
    end
    for (n = 0; n < count; n++) begin
      kind   = $urandom % 16;
      rd     = 1 + $urandom % 7;
      rs1    = $urandom % 8;
      rs2    = $urandom % 8;
      imm    = $urandom;
      offset = ($urandom % 64) * 4;
      case (kind)
        0:  put(i_type(imm, rs1, 3'b000, rd, OPC_IMM));
        1:  put(i_type(imm, rs1, 3'b111, rd, OPC_IMM));
        2:  put(i_type(imm, rs1, 3'b110, rd, OPC_IMM));
        3:  put(i_type(imm, rs1, 3'b100, rd, OPC_IMM));
        4:  put(i_type(imm, rs1, 3'b010, rd, OPC_IMM));
        5:  put(r_type(7'h00, rs2, rs1, 3'b000, rd));
        6:  put(r_type(7'h20, rs2, rs1, 3'b000, rd));
        7:  put(r_type(7'h00, rs2, rs1, 3'b111, rd));
        8:  put(r_type(7'h00, rs2, rs1, 3'b110, rd));
        9:  put(r_type(7'h00, rs2, rs1, 3'b100, rd));
        10: put(r_type(7'h00, rs2, rs1, 3'b010, rd));
        11: put(lui_word(imm[31:12], rd));
        12, 13: put(i_type(offset, rs1, 3'b010, rd, OPC_LOAD));
        default: put(s_type(offset, rs2, rs1));
      endcase
    end
    store_all_regs(12'h300);
  endtask

  initial begin
    reset        = 1'b1;
    pend_valid   = 1'b0;
    pend_addr    = '0;
    pend_data    = '0;
    store_idx    = 0;
    test_errors  = 0;
    test_num     = 0;
    tests_failed = 0;
    wr_ptr       = 0;
    seed_state   = $urandom(32'h3af87368);

    // immediate, register and lui forms
    start_program();
    put(lui_word(20'h12345, 1));
    put(i_type(12'h678, 1, 3'b000, 1, OPC_IMM));
    put(i_type(-5, 0, 3'b000, 2, OPC_IMM));
    put(i_type(12'h0f0, 1, 3'b100, 3, OPC_IMM));
    put(i_type(12'h333, 2, 3'b110, 4, OPC_IMM));
    put(i_type(12'h7f0, 1, 3'b111, 5, OPC_IMM));
    put(i_type(3, 2, 3'b010, 6, OPC_IMM));
    put(i_type(-1, 1, 3'b010, 7, OPC_IMM));
    put(r_type(7'h00, 2, 1, 3'b000, 8));
    put(r_type(7'h20, 2, 1, 3'b000, 9));
    put(r_type(7'h00, 2, 1, 3'b111, 10));
    put(r_type(7'h00, 2, 1, 3'b110, 11));
    put(r_type(7'h00, 2, 1, 3'b100, 12));
    put(r_type(7'h00, 1, 2, 3'b010, 13));
    put(r_type(7'h00, 2, 1, 3'b010, 14));
    put(lui_word(20'hfffff, 15));
    store_all_regs(0);
    finish_program("alu and lui");

    // dependences at distance one, two and three
    start_program();
    put(i_type(1, 0, 3'b000, 1, OPC_IMM));
    put(i_type(2, 1, 3'b000, 2, OPC_IMM));
    put(r_type(7'h00, 1, 2, 3'b000, 3));
    put(i_type(7, 0, 3'b000, 4, OPC_IMM));
    put(i_type(1, 0, 3'b000, 5, OPC_IMM));
    put(r_type(7'h20, 5, 4, 3'b000, 6));
    put(i_type(9, 0, 3'b000, 7, OPC_IMM));
    put(i_type(3, 0, 3'b000, 8, OPC_IMM));
    put(i_type(2, 0, 3'b000, 9, OPC_IMM));
    put(r_type(7'h00, 9, 7, 3'b100, 10));
    put(r_type(7'h00, 10, 8, 3'b010, 11));
    put(s_type(12'h040, 11, 0));
    store_all_regs(12'h080);
    finish_program("dependent chains");

    // load then immediate use and a store of loaded data
    start_program();
    put(i_type(12'h040, 0, 3'b010, 1, OPC_LOAD));
    put(i_type(1, 1, 3'b000, 2, OPC_IMM));
    put(s_type(12'h100, 2, 0));
    put(i_type(12'h044, 0, 3'b010, 3, OPC_LOAD));
    put(s_type(12'h104, 3, 0));
    put(s_type(12'h080, 2, 0));
    put(i_type(12'h080, 0, 3'b010, 6, OPC_LOAD));
    put(s_type(12'h108, 6, 0));
    put(i_type(12'h048, 0, 3'b010, 4, OPC_LOAD));
    // address taken from loaded data
    put(i_type(0, 4, 3'b010, 5, OPC_LOAD));
    put(s_type(12'h10c, 5, 0));
    finish_program("load use");

    // beq and bne both ways plus a short loop
    start_program();
    put(i_type(5, 0, 3'b000, 1, OPC_IMM));
    put(i_type(5, 0, 3'b000, 2, OPC_IMM));
    put(i_type(6, 0, 3'b000, 3, OPC_IMM));
    put(b_type(12, 2, 1, 3'b000));
    put(s_type(12'h200, 1, 0));
    put(s_type(12'h204, 1, 0));
    put(s_type(12'h208, 2, 0));
    put(b_type(12, 2, 1, 3'b001));
    put(s_type(12'h20c, 3, 0));
    put(b_type(8, 3, 1, 3'b000));
    put(s_type(12'h210, 3, 0));
    put(b_type(8, 3, 1, 3'b001));
    put(s_type(12'h214, 1, 0));
    put(i_type(3, 0, 3'b000, 4, OPC_IMM));
    put(s_type(12'h220, 4, 0));
    put(i_type(-1, 4, 3'b000, 4, OPC_IMM));
    put(b_type(-8, 0, 4, 3'b001));
    put(s_type(12'h224, 4, 0));
    finish_program("branches");

    // jal with link use right after
    start_program();
    put(i_type(12'h011, 0, 3'b000, 1, OPC_IMM));
    put(jal_word(12, 5));
    put(s_type(12'h300, 1, 0));
    put(s_type(12'h304, 1, 0));
    put(s_type(12'h308, 5, 0));
    put(jal_word(8, 0));
    put(i_type(12'h077, 0, 3'b000, 1, OPC_IMM));
    put(i_type(12'h022, 1, 3'b000, 6, OPC_IMM));
    put(s_type(12'h30c, 6, 0));
    put(jal_word(8, 7));
    put(s_type(12'h310, 7, 0));
    put(s_type(12'h314, 7, 0));
    finish_program("jal");

    // random alu, load and store mix
    start_program();
    build_random_program(200);
    finish_program("random mix");

    $display("tests run %0d, passed %0d, failed %0d",
             test_num, test_num - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/riscv_pkg.sv
logic/pipe_reg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/hazard_unit.sv
logic/riscv_pipelined.sv
dv/riscv_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_pipelined

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/riscv_pkg.sv
      - logic/pipe_reg.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/hazard_unit.sv
      - logic/riscv_pipelined.sv
  - target: test
    files:
      - dv/riscv_tb.sv
